//--- run.sh
#!/bin/sh
# Build and run the wide ALU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tbExWideAlu -Mdir obj_dir -f src.f
output=$(./obj_dir/VtbExWideAlu || true)
echo "$output"
if echo "$output" | grep -q "^TEST PASSED$"; then
	exit 0
fi
exit 1

//--- src.f
src/exPkg.sv
src/exCsAdd72C.sv
src/exAddPath.sv
src/exLogic72.sv
src/exResultMux.sv
src/exWbRegs.sv
src/exWideAluTop.sv
verification/exWideAlu_asserts.sv
verification/tbExWideAlu.sv

//--- src/exAddPath.sv
// Arithmetic operand conditioning
// Inverts B for subtraction and picks the adder carry-in per opcode,
// then drives the carry-select adder. For SUB and SBB the carry-out
// reads as "no borrow".

`default_nettype none

module exAddPath
(
	input wire exPkg::aluReq_t req,
	output logic [exPkg::OperandWidth:0] sum
);

	logic [exPkg::OperandWidth-1:0] addB;
	logic addCin;

	always_comb
	begin
		case (req.op)
			exPkg::OP_ADC:
			begin
				addB = req.valB;
				addCin = req.cin;
			end
			exPkg::OP_SUB:
			begin
				addB = ~req.valB;
				addCin = 1'b1;	// Two's complement
			end
			exPkg::OP_SBB:
			begin
				addB = ~req.valB;
				addCin = req.cin;
			end
			default:
			begin
				addB = req.valB;
				addCin = 1'b0;
			end
		endcase
	end

	exCsAdd72C uAdd
	(
		.valA(req.valA),
		.valB(addB),
		.cin(addCin),
		.valC(sum)
	);

endmodule

`default_nettype wire

//--- src/exCsAdd72C.sv
// 72-bit carry-select adder
// Six 12-bit blocks are summed for both carry-ins. A three level select
// tree over the block carry-outs resolves the carry into each block,
// starting from cin. Bit 72 of valC is the final carry. Combinational.

`default_nettype none

module exCsAdd72C
(
	input wire logic [exPkg::OperandWidth-1:0] valA,
	input wire logic [exPkg::OperandWidth-1:0] valB,
	input wire logic cin,
	output logic [exPkg::OperandWidth:0] valC
);

	logic [12:0] sum0 [0:5];	// Block sums, carry-in 0
	logic [12:0] sum1 [0:5];	// Block sums, carry-in 1
	logic [1:0] pairCo0 [0:2];	// Block couts of a pair, pair cin 0
	logic [1:0] pairCo1 [0:2];
	logic [3:0] quadCo0;	// Couts of blocks 0..3
	logic [3:0] quadCo1;
	logic [5:0] blkCo0;	// Couts of all blocks
	logic [5:0] blkCo1;
	logic [6:0] blkCin;	// Carry into each block, bit 6 is cout

	always_comb
	begin
		for (int i = 0; i < 6; i++)
		begin
			sum0[i] = {1'b0, valA[i*12 +: 12]} + {1'b0, valB[i*12 +: 12]};
			sum1[i] = {1'b0, valA[i*12 +: 12]} + {1'b0, valB[i*12 +: 12]} + 13'd1;
		end

		for (int p = 0; p < 3; p++)
		begin
			pairCo0[p] = {sum0[2*p][12] ? sum1[2*p+1][12] : sum0[2*p+1][12],
				sum0[2*p][12]};
			pairCo1[p] = {sum1[2*p][12] ? sum1[2*p+1][12] : sum0[2*p+1][12],
				sum1[2*p][12]};
		end

		quadCo0 = {pairCo0[0][1] ? pairCo1[1] : pairCo0[1], pairCo0[0]};
		quadCo1 = {pairCo1[0][1] ? pairCo1[1] : pairCo0[1], pairCo1[0]};

		blkCo0 = {quadCo0[3] ? pairCo1[2] : pairCo0[2], quadCo0};
		blkCo1 = {quadCo1[3] ? pairCo1[2] : pairCo0[2], quadCo1};

		blkCin = {cin ? blkCo1 : blkCo0, cin};

		for (int i = 0; i < 6; i++)
		begin
			valC[i*12 +: 12] = blkCin[i] ? sum1[i][11:0] : sum0[i][11:0];
		end
		valC[72] = blkCin[6];
	end

endmodule

`default_nettype wire

//--- src/exLogic72.sv
// 72-bit bitwise unit
// AND, OR or XOR of the two operands. Arithmetic opcodes give zero.

`default_nettype none

module exLogic72
(
	input wire exPkg::aluReq_t req,
	output logic [exPkg::OperandWidth-1:0] logicOut
);

	always_comb
	begin
		case (req.op)
			exPkg::OP_AND:
			begin
				logicOut = req.valA & req.valB;
			end
			exPkg::OP_OR:
			begin
				logicOut = req.valA | req.valB;
			end
			exPkg::OP_XOR:
			begin
				logicOut = req.valA ^ req.valB;
			end
			default:
			begin
				logicOut = '0;	// Unused by result stage
			end
		endcase
	end

endmodule

`default_nettype wire

//--- src/exPkg.sv
// Wide ALU shared definitions
// Opcodes, the request and result bundles passed between the register
// block and the arithmetic units, and the Wishbone register word map.

`default_nettype none

package exPkg;

	localparam int OperandWidth = 72;
	localparam int BusWidth = 32;

	// Word indices taken from adr[5:2]
	localparam logic [3:0] RegA0 = 4'd0;
	localparam logic [3:0] RegA1 = 4'd1;
	localparam logic [3:0] RegA2 = 4'd2;	// Bits 71:64 in low byte
	localparam logic [3:0] RegB0 = 4'd3;
	localparam logic [3:0] RegB1 = 4'd4;
	localparam logic [3:0] RegB2 = 4'd5;
	localparam logic [3:0] RegCtrl = 4'd6;	// op in 2:0, cin in 3
	localparam logic [3:0] RegRes0 = 4'd7;
	localparam logic [3:0] RegRes1 = 4'd8;
	localparam logic [3:0] RegRes2 = 4'd9;
	localparam logic [3:0] RegFlags = 4'd10;	// carry in 0, zero in 1

	typedef enum logic [2:0]
	{
		OP_ADD = 3'd0,
		OP_ADC = 3'd1,
		OP_SUB = 3'd2,
		OP_SBB = 3'd3,
		OP_AND = 3'd4,
		OP_OR = 3'd5,
		OP_XOR = 3'd6
	} aluOp_t;

	typedef struct packed
	{
		logic [OperandWidth-1:0] valA;
		logic [OperandWidth-1:0] valB;
		aluOp_t op;
		logic cin;
	} aluReq_t;

	typedef struct packed
	{
		logic [OperandWidth-1:0] value;
		logic carry;
		logic zero;
	} aluRes_t;

endpackage

`default_nettype wire

//--- src/exResultMux.sv
// Result stage
// Picks the adder or logic output by opcode, forms carry and zero,
// and captures all three in the result register on start.

`default_nettype none

module exResultMux
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic start,
	input wire exPkg::aluOp_t op,
	input wire logic [exPkg::OperandWidth:0] sum,
	input wire logic [exPkg::OperandWidth-1:0] logicOut,
	output exPkg::aluRes_t res
);

	logic isLogic;
	exPkg::aluRes_t nextRes;

	always_comb
	begin
		isLogic = (op == exPkg::OP_AND) || (op == exPkg::OP_OR) || (op == exPkg::OP_XOR);
		nextRes.value = isLogic ? logicOut : sum[exPkg::OperandWidth-1:0];
		nextRes.carry = isLogic ? 1'b0 : sum[exPkg::OperandWidth];
		nextRes.zero = ~|nextRes.value;
	end

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			res.value <= '0;
			res.carry <= 1'b0;
			res.zero <= 1'b1;	// Matches the zero value
		end
		else if (start)
		begin
			res <= nextRes;
		end
	end

endmodule

`default_nettype wire

//--- src/exWbRegs.sv
// Wishbone classic register block
// Holds the operand words and control fields written by the host.
// A RegCtrl write loads op and cin and pulses start for one cycle.
// Reads return operands, control, result words and flags. Every
// access is acknowledged one cycle after it is presented.

`default_nettype none

module exWbRegs
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [5:0] adr,
	input wire logic [exPkg::BusWidth-1:0] datWr,
	output logic [exPkg::BusWidth-1:0] datRd,
	output logic ack,
	output exPkg::aluReq_t req,
	output logic start,
	input wire exPkg::aluRes_t res
);

	logic [3:0] wordIdx;
	logic accept;
	logic wrAccept;

	assign wordIdx = adr[5:2];
	assign accept = cyc && stb && !ack;
	assign wrAccept = accept && we;

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			ack <= 1'b0;
			start <= 1'b0;
			req.valA <= '0;
			req.valB <= '0;
			req.op <= exPkg::OP_ADD;
			req.cin <= 1'b0;
		end
		else
		begin
			ack <= accept;
			start <= wrAccept && (wordIdx == exPkg::RegCtrl);
			if (wrAccept)
			begin
				case (wordIdx)
					exPkg::RegA0: req.valA[31:0] <= datWr;
					exPkg::RegA1: req.valA[63:32] <= datWr;
					exPkg::RegA2: req.valA[71:64] <= datWr[7:0];
					exPkg::RegB0: req.valB[31:0] <= datWr;
					exPkg::RegB1: req.valB[63:32] <= datWr;
					exPkg::RegB2: req.valB[71:64] <= datWr[7:0];
					exPkg::RegCtrl:
					begin
						if (datWr[2:0] == 3'd7)
						begin
							req.op <= exPkg::OP_ADD;	// Reserved code
						end
						else
						begin
							req.op <= exPkg::aluOp_t'(datWr[2:0]);
						end
						req.cin <= datWr[3];
					end
					default:
					begin
					end
				endcase
			end
		end
	end

	// Master holds adr through the ack cycle
	always_comb
	begin
		case (wordIdx)
			exPkg::RegA0: datRd = req.valA[31:0];
			exPkg::RegA1: datRd = req.valA[63:32];
			exPkg::RegA2: datRd = {24'd0, req.valA[71:64]};
			exPkg::RegB0: datRd = req.valB[31:0];
			exPkg::RegB1: datRd = req.valB[63:32];
			exPkg::RegB2: datRd = {24'd0, req.valB[71:64]};
			exPkg::RegCtrl: datRd = {28'd0, req.cin, req.op};
			exPkg::RegRes0: datRd = res.value[31:0];
			exPkg::RegRes1: datRd = res.value[63:32];
			exPkg::RegRes2: datRd = {24'd0, res.value[71:64]};
			exPkg::RegFlags: datRd = {30'd0, res.zero, res.carry};
			default: datRd = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- src/exWideAluTop.sv
// Wide ALU top level
// Wishbone register block feeding the add path and logic unit, with
// the result stage registering the outcome for readback.

`default_nettype none

module exWideAluTop
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [5:0] adr,
	input wire logic [exPkg::BusWidth-1:0] datWr,
	output logic [exPkg::BusWidth-1:0] datRd,
	output logic ack
);

	exPkg::aluReq_t req;
	exPkg::aluRes_t res;
	logic start;
	logic [exPkg::OperandWidth:0] sum;
	logic [exPkg::OperandWidth-1:0] logicOut;

	exWbRegs uRegs
	(
		.clock(clock),
		.rstN(rstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWr(datWr),
		.datRd(datRd),
		.ack(ack),
		.req(req),
		.start(start),
		.res(res)
	);

	exAddPath uAddPath
	(
		.req(req),
		.sum(sum)
	);

	exLogic72 uLogic
	(
		.req(req),
		.logicOut(logicOut)
	);

	exResultMux uResult
	(
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.op(req.op),
		.sum(sum),
		.logicOut(logicOut),
		.res(res)
	);

endmodule

`default_nettype wire

//--- verification/exWideAlu_asserts.sv
// Wide ALU assertion checks
// Wishbone ack handshake and result register timing, bound into the
// top level.

`default_nettype none

module exWideAluAsserts
(
	input wire logic clock,
	input wire logic rstN,
	input wire logic cyc,
	input wire logic stb,
	input wire logic ack,
	input wire logic start,
	input wire exPkg::aluRes_t res
);

	int failCount = 0;

	ackOnePulse: assert property (@(posedge clock) disable iff (!rstN) ack |=> !ack)
	else
	begin
		failCount++;
		$error("ack high for two cycles in a row");
	end

	ackOnRequest: assert property (@(posedge clock) disable iff (!rstN)
		$rose(ack) |-> $past(cyc && stb))
	else
	begin
		failCount++;
		$error("ack rose without cyc and stb");
	end

	resAfterStart: assert property (@(posedge clock) disable iff (!rstN)
		!$past(start) |-> $stable(res))
	else
	begin
		failCount++;
		$error("res changed outside the cycle after start");
	end

endmodule

bind exWideAluTop exWideAluAsserts uAsserts
(
	.clock(clock),
	.rstN(rstN),
	.cyc(cyc),
	.stb(stb),
	.ack(ack),
	.start(start),
	.res(res)
);

`default_nettype wire

//--- verification/tbExWideAlu.sv
// Wide ALU testbench
// Drives the Wishbone port of the top level with directed and xorshift
// random operations. Each result is checked against a wide arithmetic
// reference model.

`default_nettype none

module tbExWideAlu;

	localparam int DriveDelay = 10;
	localparam int AckTimeout = 20;
	localparam logic [31:0] Seed = 32'ha066_38ce;

	logic clock;
	logic rstN;
	logic cyc;
	logic stb;
	logic we;
	logic [5:0] adr;
	logic [31:0] datWr;
	logic [31:0] datRd;
	logic ack;

	logic [31:0] rngState;
	int checks;
	int valueErrs;
	int flagErrs;
	int totalErrs;
	logic [71:0] a;
	logic [71:0] b;
	logic [2:0] opCode;
	logic cinBit;
	logic [72:0] held;

	exWideAluTop DUT
	(
		.clock(clock),
		.rstN(rstN),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.datWr(datWr),
		.datRd(datRd),
		.ack(ack)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Expected {carry, value}
	function automatic logic [72:0] modelAlu(input logic [71:0] x, input logic [71:0] y,
		input logic [2:0] code, input logic c);
		case (code)
			exPkg::OP_ADC: return {1'b0, x} + {1'b0, y} + {72'd0, c};
			exPkg::OP_SUB: return {x >= y, x - y};	// Carry means no borrow
			exPkg::OP_SBB: return {1'b0, x} + {1'b0, ~y} + {72'd0, c};
			exPkg::OP_AND: return {1'b0, x & y};
			exPkg::OP_OR: return {1'b0, x | y};
			exPkg::OP_XOR: return {1'b0, x ^ y};
			default: return {1'b0, x} + {1'b0, y};	// ADD and reserved code
		endcase
	endfunction

	task automatic randOperand(output logic [71:0] v);
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		rngState = xorshift32(rngState);
		w0 = rngState;
		rngState = xorshift32(rngState);
		w1 = rngState;
		rngState = xorshift32(rngState);
		w2 = rngState;
		v = {w2[7:0], w1, w0};
	endtask

	task automatic busAccess(input logic write, input logic [3:0] idx,
		input logic [31:0] data, output logic [31:0] rdData);
		int waitCnt;
		logic gotAck;
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = {idx, 2'b00};
		datWr = data;
		waitCnt = 0;
		gotAck = 1'b0;
		while (!gotAck && waitCnt < AckTimeout)
		begin
			@(posedge clock);
			#DriveDelay;
			gotAck = ack;
			waitCnt++;
		end
		rdData = datRd;	// Valid in the ack cycle
		if (!gotAck)
		begin
			$display("Timeout: %s of word %0d got no ack", write ? "write" : "read", idx);
			$display("TEST FAILED");
			$finish;
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task automatic wbWrite(input logic [3:0] idx, input logic [31:0] data);
		logic [31:0] unused;
		busAccess(1'b1, idx, data, unused);
	endtask

	task automatic wbRead(input logic [3:0] idx, output logic [31:0] data);
		busAccess(1'b0, idx, 32'd0, data);
	endtask

	task automatic compareResult(input logic [72:0] expVal, input string what);
		logic [31:0] w0;
		logic [31:0] w1;
		logic [31:0] w2;
		logic [31:0] flags;
		logic [71:0] got;
		logic expZero;
		wbRead(exPkg::RegRes0, w0);
		wbRead(exPkg::RegRes1, w1);
		wbRead(exPkg::RegRes2, w2);
		wbRead(exPkg::RegFlags, flags);
		got = {w2[7:0], w1, w0};
		expZero = (expVal[71:0] == 72'd0);
		checks++;
		if (got !== expVal[71:0])
		begin
			valueErrs++;
			$display("** Error at %0t: %s value %h, expected %h", $time, what, got,
				expVal[71:0]);
		end
		if (flags[1:0] !== {expZero, expVal[72]})
		begin
			flagErrs++;
			$display("** Error at %0t: %s flags zero=%b carry=%b, expected zero=%b carry=%b",
				$time, what, flags[1], flags[0], expZero, expVal[72]);
		end
	endtask

	task automatic checkOp(input logic [71:0] x, input logic [71:0] y,
		input logic [2:0] code, input logic c);
		wbWrite(exPkg::RegA0, x[31:0]);
		wbWrite(exPkg::RegA1, x[63:32]);
		wbWrite(exPkg::RegA2, {24'd0, x[71:64]});
		wbWrite(exPkg::RegB0, y[31:0]);
		wbWrite(exPkg::RegB1, y[63:32]);
		wbWrite(exPkg::RegB2, {24'd0, y[71:64]});
		wbWrite(exPkg::RegCtrl, {28'd0, c, code});
		compareResult(modelAlu(x, y, code, c), $sformatf("op %0d cin %0b", code, c));
	endtask

	initial
	begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial
	begin
		rstN = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 6'd0;
		datWr = 32'd0;
		rngState = Seed;
		checks = 0;
		valueErrs = 0;
		flagErrs = 0;
		repeat (3) @(posedge clock);
		#DriveDelay;
		rstN = 1'b1;

		compareResult(73'd0, "after reset");

		// Carry ripples through every 12-bit block
		checkOp({72{1'b1}}, 72'd1, exPkg::OP_ADD, 1'b0);
		checkOp({72{1'b1}}, 72'd0, exPkg::OP_ADC, 1'b1);
		checkOp({6{12'h800}}, {6{12'h800}}, exPkg::OP_ADD, 1'b0);
		checkOp({6{12'hfff}}, {6{12'h001}}, exPkg::OP_ADC, 1'b1);
		randOperand(a);
		checkOp(a, a, exPkg::OP_SUB, 1'b0);
		checkOp(72'd0, 72'd1, exPkg::OP_SUB, 1'b0);	// Borrow
		checkOp(a, a, exPkg::OP_SBB, 1'b1);
		checkOp(a, a, exPkg::OP_SBB, 1'b0);
		checkOp(a, ~a, exPkg::OP_AND, 1'b1);
		checkOp(a, ~a, exPkg::OP_OR, 1'b0);
		checkOp(a, a, exPkg::OP_XOR, 1'b1);
		checkOp({72{1'b1}}, 72'd1, 3'd7, 1'b1);	// Reserved code

		// Result holds over an operand write until the next RegCtrl write
		randOperand(a);
		randOperand(b);
		checkOp(a, b, exPkg::OP_ADD, 1'b0);
		held = modelAlu(a, b, exPkg::OP_ADD, 1'b0);
		wbWrite(exPkg::RegA0, ~a[31:0]);
		compareResult(held, "after operand write");
		wbWrite(exPkg::RegCtrl, {28'd0, 1'b0, exPkg::OP_ADD});
		compareResult(modelAlu({a[71:32], ~a[31:0]}, b, exPkg::OP_ADD, 1'b0), "recompute");

		for (int i = 0; i < 60; i++)
		begin
			randOperand(a);
			randOperand(b);
			rngState = xorshift32(rngState);
			opCode = rngState[2:0];
			cinBit = rngState[3];
			if (rngState[6:4] == 3'd0)
			begin
				b = a;	// Exercise the zero flag
			end
			checkOp(a, b, opCode, cinBit);
		end

		totalErrs = valueErrs + flagErrs + DUT.uAsserts.failCount;
		$display("Checks %0d, value errors %0d, flag errors %0d, assertion errors %0d",
			checks, valueErrs, flagErrs, DUT.uAsserts.failCount);
		if (totalErrs == 0)
		begin
			$display("TEST PASSED");
		end
		else
		begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
